/* all.f */
hw/x11_pkg.sv
hw/x11_ctrl_regs.sv
hw/sha256_feed_fifo.sv
hw/sha256_hash_capture.sv
hw/sys_bus_port.sv
hw/x11_regs_top.sv
verif/tb_clk_gen.sv
verif/x11_regs_props.sv
verif/tb_x11_regs.sv

/* hw/sha256_feed_fifo.sv */
`timescale 1ns/1ps

module sha256_feed_fifo (
  input  logic                       clk_125mhz,
  input  logic                       sha_rstn_i,   // channel reset clears everything
  input  logic                       push_en_i,
  input  logic [x11_pkg::DATA_W-1:0] push_data_i,
  input  logic                       pop_en_i,     // engine read request
  input  logic                       eng_rdy_i,
  output logic                       pop_vld_o,
  output logic [x11_pkg::DATA_W-1:0] pop_data_o,
  output logic [x11_pkg::CNT_W-1:0]  count_o,
  output logic                       empty_o,
  output logic                       m1full_o,
  output logic                       full_o,
  output logic                       start_o       // engine start pulse
);
  import x11_pkg::*;

  logic [DATA_W-1:0]               mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic                            push_ok;
  logic                            pop_ok;
  logic                            feed_rdy;     // data waiting and engine idle
  logic                            feed_rdy_q;

  // flags straight from the occupancy
  assign empty_o  = (count_o == '0);
  assign full_o   = (count_o == CNT_W'(FIFO_DEPTH));
  assign m1full_o = (count_o == CNT_W'(FIFO_DEPTH - 1));

  assign push_ok = push_en_i & ~full_o;   // push into full is dropped
  assign pop_ok  = pop_en_i & ~empty_o;   // pop on empty ignored

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge clk_125mhz) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data_i;
    end
    if (pop_ok) begin
      pop_data_o <= mem[rd_ptr];  // shows up with pop_vld_o
    end
  end

  // pointers and count
  always_ff @(posedge clk_125mhz) begin
    if (!sha_rstn_i) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count_o   <= '0;
      pop_vld_o <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        count_o <= count_o + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_o <= count_o - 1'b1;
      end
      pop_vld_o <= pop_ok;
    end
  end

  // --------------------
  // engine start
  // --------------------
  assign feed_rdy = ~empty_o & eng_rdy_i;

  always_ff @(posedge clk_125mhz) begin
    if (!sha_rstn_i) begin
      feed_rdy_q <= 1'b0;
      start_o    <= 1'b0;
    end else begin
      feed_rdy_q <= feed_rdy;
      start_o    <= feed_rdy & ~feed_rdy_q;  // single pulse per rising condition
    end
  end

endmodule

/* hw/sha256_hash_capture.sv */
`timescale 1ns/1ps

module sha256_hash_capture (
  input  logic                                                 clk_125mhz,
  input  logic                                                 sha_rstn_i,
  input  logic                                                 hash_valid_i,  // held by engine
  input  logic [x11_pkg::HASH_W-1:0]                           hash_i,
  output logic [x11_pkg::HASH_WORDS-1:0][x11_pkg::DATA_W-1:0]  hash_words_o,  // [0] is H7
  output logic                                                 hash_valid_o
);
  import x11_pkg::*;

  logic hash_rise;  // first cycle of valid

  // hash_valid_o doubles as the edge detector history
  assign hash_rise = hash_valid_i & ~hash_valid_o;

  always_ff @(posedge clk_125mhz) begin
    if (!sha_rstn_i) begin
      hash_valid_o <= 1'b0;
      hash_words_o <= '0;
    end else begin
      hash_valid_o <= hash_valid_i;
      if (hash_rise) begin
        for (int i = 0; i < HASH_WORDS; i++) begin
          hash_words_o[i] <= hash_i[i*DATA_W +: DATA_W];  // lsb slice goes to H7
        end
      end
    end
  end

endmodule

/* hw/sys_bus_port.sv */
`timescale 1ns/1ps

module sys_bus_port (
  input  logic                                                 clk_125mhz,
  input  logic                                                 rstn_125mhz,
  // host side
  input  logic [x11_pkg::DATA_W-1:0]                           sys_addr_i,
  input  logic [x11_pkg::DATA_W-1:0]                           sys_wdata_i,
  input  logic                                                 sys_wen_i,
  input  logic                                                 sys_ren_i,
  // register sources
  input  logic [x11_pkg::DATA_W-1:0]                           ctrl_i,
  input  logic [x11_pkg::DATA_W-1:0]                           sha_ctrl_i,
  input  logic [x11_pkg::DATA_W-1:0]                           kek_ctrl_i,
  input  logic                                                 x11_act_i,
  input  logic                                                 sha_act_i,
  input  logic                                                 kek_act_i,
  input  logic [x11_pkg::CNT_W-1:0]                            fifo_count_i,
  input  logic                                                 fifo_empty_i,
  input  logic                                                 fifo_m1full_i,
  input  logic                                                 fifo_full_i,
  input  logic                                                 sha_rdy_i,
  input  logic                                                 hash_valid_i,
  input  logic [x11_pkg::HASH_WORDS-1:0][x11_pkg::DATA_W-1:0]  hash_words_i,
  // write strobes
  output logic                                                 ctrl_wr_o,
  output logic                                                 sha_ctrl_wr_o,
  output logic                                                 kek_ctrl_wr_o,
  output logic [x11_pkg::DATA_W-1:0]                           wdata_o,
  output logic                                                 push_en_o,
  output logic [x11_pkg::DATA_W-1:0]                           push_data_o,
  // host return
  output logic [x11_pkg::DATA_W-1:0]                           sys_rdata_o,
  output logic                                                 sys_ack_o,
  output logic                                                 sys_err_o
);
  import x11_pkg::*;

  logic [ADDR_DEC_W-1:0]          addr;        // decoded part of the address
  logic [ADDR_DEC_W-1:0]          hash_off;    // offset into hash window
  logic [$clog2(HASH_WORDS)-1:0]  hash_idx;
  logic                           hash_hit;
  logic [DATA_W-1:0]              status;
  logic [DATA_W-1:0]              sha_status;
  logic [DATA_W-1:0]              count_word;
  logic [DATA_W-1:0]              rd_mux;

  assign addr = sys_addr_i[ADDR_DEC_W-1:0];

  // --------------------
  // write decode
  // --------------------
  assign ctrl_wr_o     = sys_wen_i && (addr == ADDR_CTRL);
  assign sha_ctrl_wr_o = sys_wen_i && (addr == ADDR_SHA_CTRL);
  assign kek_ctrl_wr_o = sys_wen_i && (addr == ADDR_KEK_CTRL);
  assign push_en_o     = sys_wen_i && (addr == ADDR_SHA_PUSH);
  assign wdata_o       = sys_wdata_i;
  assign push_data_o   = sys_wdata_i;  // message word into fifo

  // --------------------
  // status words
  // --------------------
  always_comb begin
    status             = '0;
    status[ST_X11_ACT] = x11_act_i;
    status[ST_SHA_ACT] = sha_act_i;
    status[ST_KEK_ACT] = kek_act_i;
  end

  always_comb begin
    sha_status               = '0;
    sha_status[SST_RDY]      = sha_rdy_i;
    sha_status[SST_HASH_VLD] = hash_valid_i;
    sha_status[SST_EMPTY]    = fifo_empty_i;
    sha_status[SST_M1FULL]   = fifo_m1full_i;
    sha_status[SST_FULL]     = fifo_full_i;
  end

  assign count_word = {{(DATA_W-CNT_W){1'b0}}, fifo_count_i};

  // hash window H7 .. H0, word aligned
  assign hash_off = addr - ADDR_SHA_HASH_H7;
  assign hash_idx = hash_off[2 +: $clog2(HASH_WORDS)];
  assign hash_hit = (addr >= ADDR_SHA_HASH_H7) && (addr <= ADDR_SHA_HASH_H0)
                  && (addr[1:0] == 2'b00);

  // read mux
  always_comb begin
    rd_mux = '0;  // unmapped reads zero
    case (addr)
      ADDR_CTRL:       rd_mux = ctrl_i;
      ADDR_STATUS:     rd_mux = status;
      ADDR_VERSION:    rd_mux = CURRENT_DATE;
      ADDR_SHA_CTRL:   rd_mux = sha_ctrl_i;
      ADDR_SHA_STATUS: rd_mux = sha_status;
      ADDR_SHA_PUSH,
      ADDR_SHA_COUNT:  rd_mux = count_word;  // one count for both views
      ADDR_KEK_CTRL:   rd_mux = kek_ctrl_i;
      ADDR_KEK_STATUS: rd_mux = '0;          // keccak engine reports nothing yet
      default:         if (hash_hit) rd_mux = hash_words_i[hash_idx];
    endcase
  end

  // --------------------
  // registered return
  // --------------------
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      sys_ack_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;  // every access acked next cycle
      if (sys_ren_i) begin
        sys_rdata_o <= rd_mux;
      end
    end
  end

  assign sys_err_o = 1'b0;  // no error path on this bus

endmodule

/* hw/x11_ctrl_regs.sv */
`timescale 1ns/1ps

module x11_ctrl_regs (
  input  logic                       clk_125mhz,
  input  logic                       rstn_125mhz,
  input  logic                       ctrl_wr_i,      // strobe from bus decode
  input  logic                       sha_ctrl_wr_i,
  input  logic                       kek_ctrl_wr_i,
  input  logic [x11_pkg::DATA_W-1:0] wdata_i,
  output logic [x11_pkg::DATA_W-1:0] ctrl_o,
  output logic [x11_pkg::DATA_W-1:0] sha_ctrl_o,
  output logic [x11_pkg::DATA_W-1:0] kek_ctrl_o,
  output logic                       x11_activated_o,
  output logic                       sha_rstn_o,     // sha channel held in reset while low
  output logic                       kek_rstn_o
);
  import x11_pkg::*;

  act_state_e state_q;
  act_state_e state_d;
  logic       x11_en;   // enable bit as held in ctrl
  logic       sha_go;   // release condition for sha channel
  logic       kek_go;

  assign x11_en = ctrl_o[CTRL_ENABLE];

  // --------------------
  // control words
  // --------------------
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      ctrl_o     <= '0;
      sha_ctrl_o <= '0;
      kek_ctrl_o <= '0;
    end else begin
      if (ctrl_wr_i) begin
        ctrl_o <= wdata_i;
      end
      if (sha_ctrl_wr_i) begin
        sha_ctrl_o <= wdata_i;
      end else begin
        sha_ctrl_o[SHA_CTRL_RESET] <= 1'b0;  // reset bit lives one cycle only
      end
      if (kek_ctrl_wr_i) begin
        kek_ctrl_o <= wdata_i;
      end
    end
  end

  // --------------------
  // activation sequencer
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (ctrl_wr_i && wdata_i[CTRL_ENABLE]) state_d = ARMED;  // arm on the write
      ARMED:   state_d = x11_en ? ACTIVE : IDLE;  // enable may be gone again
      ACTIVE:  if (!x11_en) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign x11_activated_o = (state_q == ACTIVE);

  // channel release needs x11 running plus own enable
  assign sha_go = x11_activated_o & x11_en & sha_ctrl_o[SHA_CTRL_ENABLE]
                & ~sha_ctrl_o[SHA_CTRL_RESET];
  assign kek_go = x11_activated_o & x11_en & kek_ctrl_o[KEK_CTRL_ENABLE];

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      sha_rstn_o <= 1'b0;
      kek_rstn_o <= 1'b0;
    end else begin
      sha_rstn_o <= sha_go;  // one cycle behind the condition
      kek_rstn_o <= kek_go;
    end
  end

endmodule

/* hw/x11_pkg.sv */
package x11_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int DATA_W     = 32;   // bus and message word
  localparam int HASH_W     = 256;  // sha-256 digest
  localparam int HASH_WORDS = 8;    // digest split into bus words
  localparam int FIFO_DEPTH = 256;  // message word entries
  localparam int CNT_W      = 9;    // occupancy 0 .. 256
  localparam int ADDR_DEC_W = 20;   // low address bits that get decoded

  // build word 0xYYMMDDss with year, month, day and serial
  localparam logic [DATA_W-1:0] CURRENT_DATE = 32'h00010101;

  // --------------------
  // address map
  // --------------------
  // common block
  localparam logic [ADDR_DEC_W-1:0] ADDR_CTRL    = 20'h00000;
  localparam logic [ADDR_DEC_W-1:0] ADDR_STATUS  = 20'h00004;
  localparam logic [ADDR_DEC_W-1:0] ADDR_VERSION = 20'h0000C;

  // sha-256 channel
  localparam logic [ADDR_DEC_W-1:0] ADDR_SHA_CTRL    = 20'h00100;
  localparam logic [ADDR_DEC_W-1:0] ADDR_SHA_STATUS  = 20'h00104;
  localparam logic [ADDR_DEC_W-1:0] ADDR_SHA_PUSH    = 20'h0010C;  // wr pushes, rd gives count
  localparam logic [ADDR_DEC_W-1:0] ADDR_SHA_HASH_H7 = 20'h00110;  // lsb word
  localparam logic [ADDR_DEC_W-1:0] ADDR_SHA_HASH_H0 =
    ADDR_SHA_HASH_H7 + ADDR_DEC_W'(4 * (HASH_WORDS - 1));          // msb word at 0x12C
  localparam logic [ADDR_DEC_W-1:0] ADDR_SHA_COUNT   = 20'h00130;

  // keccak channel
  localparam logic [ADDR_DEC_W-1:0] ADDR_KEK_CTRL   = 20'h00200;
  localparam logic [ADDR_DEC_W-1:0] ADDR_KEK_STATUS = 20'h00204;

  // --------------------
  // bit positions
  // --------------------
  localparam int CTRL_ENABLE     = 0;
  localparam int SHA_CTRL_ENABLE = 0;
  localparam int SHA_CTRL_RESET  = 1;  // self clearing
  localparam int KEK_CTRL_ENABLE = 0;

  // common status word
  localparam int ST_X11_ACT = 0;
  localparam int ST_SHA_ACT = 4;
  localparam int ST_KEK_ACT = 8;

  // sha status word
  localparam int SST_RDY      = 0;
  localparam int SST_HASH_VLD = 1;
  localparam int SST_EMPTY    = 4;
  localparam int SST_M1FULL   = 5;
  localparam int SST_FULL     = 6;

  // activation sequencer
  typedef enum logic [1:0] {
    IDLE,    // x11 block held off
    ARMED,   // enable written, waiting one cycle
    ACTIVE   // x11 block running
  } act_state_e;

endpackage

/* hw/x11_regs_top.sv */
`timescale 1ns/1ps

module x11_regs_top (
  input  logic                        clk_125mhz,
  input  logic                        rstn_125mhz,
  // system bus
  input  logic [x11_pkg::DATA_W-1:0]  sys_addr_i,
  input  logic [x11_pkg::DATA_W-1:0]  sys_wdata_i,
  input  logic                        sys_wen_i,
  input  logic                        sys_ren_i,
  output logic [x11_pkg::DATA_W-1:0]  sys_rdata_o,
  output logic                        sys_ack_o,
  output logic                        sys_err_o,
  output logic                        x11_activated_o,
  // sha-256 engine
  input  logic                        sha_rdy_i,
  input  logic                        sha_fifo_rd_en_i,
  input  logic                        sha_hash_valid_i,
  input  logic [x11_pkg::HASH_W-1:0]  sha_hash_i,
  output logic                        sha_start_o,
  output logic                        sha_fifo_rd_vld_o,
  output logic [x11_pkg::DATA_W-1:0]  sha_fifo_rd_data_o
);
  import x11_pkg::*;

  // control path
  logic [DATA_W-1:0]                   ctrl;
  logic [DATA_W-1:0]                   sha_ctrl;
  logic [DATA_W-1:0]                   kek_ctrl;
  logic                                sha_rstn;   // sha channel reset
  logic                                kek_rstn;   // keccak channel reset
  logic                                ctrl_wr;
  logic                                sha_ctrl_wr;
  logic                                kek_ctrl_wr;
  logic [DATA_W-1:0]                   wdata;
  // fifo
  logic                                push_en;
  logic [DATA_W-1:0]                   push_data;
  logic [CNT_W-1:0]                    fifo_count;
  logic                                fifo_empty;
  logic                                fifo_m1full;
  logic                                fifo_full;
  // hash
  logic [HASH_WORDS-1:0][DATA_W-1:0]   hash_words;
  logic                                hash_valid;

  x11_ctrl_regs i_ctrl_regs (
    .clk_125mhz      (clk_125mhz),
    .rstn_125mhz     (rstn_125mhz),
    .ctrl_wr_i       (ctrl_wr),
    .sha_ctrl_wr_i   (sha_ctrl_wr),
    .kek_ctrl_wr_i   (kek_ctrl_wr),
    .wdata_i         (wdata),
    .ctrl_o          (ctrl),
    .sha_ctrl_o      (sha_ctrl),
    .kek_ctrl_o      (kek_ctrl),
    .x11_activated_o (x11_activated_o),
    .sha_rstn_o      (sha_rstn),
    .kek_rstn_o      (kek_rstn)
  );

  sha256_feed_fifo i_feed_fifo (
    .clk_125mhz  (clk_125mhz),
    .sha_rstn_i  (sha_rstn),
    .push_en_i   (push_en),
    .push_data_i (push_data),
    .pop_en_i    (sha_fifo_rd_en_i),
    .eng_rdy_i   (sha_rdy_i),
    .pop_vld_o   (sha_fifo_rd_vld_o),
    .pop_data_o  (sha_fifo_rd_data_o),
    .count_o     (fifo_count),
    .empty_o     (fifo_empty),
    .m1full_o    (fifo_m1full),
    .full_o      (fifo_full),
    .start_o     (sha_start_o)
  );

  sha256_hash_capture i_hash_capture (
    .clk_125mhz   (clk_125mhz),
    .sha_rstn_i   (sha_rstn),
    .hash_valid_i (sha_hash_valid_i),
    .hash_i       (sha_hash_i),
    .hash_words_o (hash_words),
    .hash_valid_o (hash_valid)
  );

  sys_bus_port i_bus_port (
    .clk_125mhz    (clk_125mhz),
    .rstn_125mhz   (rstn_125mhz),
    .sys_addr_i    (sys_addr_i),
    .sys_wdata_i   (sys_wdata_i),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .ctrl_i        (ctrl),
    .sha_ctrl_i    (sha_ctrl),
    .kek_ctrl_i    (kek_ctrl),
    .x11_act_i     (x11_activated_o),
    .sha_act_i     (sha_rstn),
    .kek_act_i     (kek_rstn),
    .fifo_count_i  (fifo_count),
    .fifo_empty_i  (fifo_empty),
    .fifo_m1full_i (fifo_m1full),
    .fifo_full_i   (fifo_full),
    .sha_rdy_i     (sha_rdy_i),
    .hash_valid_i  (hash_valid),
    .hash_words_i  (hash_words),
    .ctrl_wr_o     (ctrl_wr),
    .sha_ctrl_wr_o (sha_ctrl_wr),
    .kek_ctrl_wr_o (kek_ctrl_wr),
    .wdata_o       (wdata),
    .push_en_o     (push_en),
    .push_data_o   (push_data),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .sys_err_o     (sys_err_o)
  );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_125mhz_o,
  output logic rstn_125mhz_o
);

  initial begin
    clk_125mhz_o = 1'b0;
    forever #4 clk_125mhz_o = ~clk_125mhz_o;  // 8 ns period
  end

  // reset low for 8 cycles, released on a rising edge
  initial begin
    rstn_125mhz_o = 1'b0;
    repeat (8) @(posedge clk_125mhz_o);
    rstn_125mhz_o <= 1'b1;
  end

endmodule

/* verif/tb_x11_regs.sv */
`timescale 1ns/1ps

module tb_x11_regs;
  import x11_pkg::*;

  localparam int          NUM_WORDS  = 20;
  localparam int          MAX_CYCLES = 4000;  // full sequence runs a few hundred cycles
  localparam logic [31:0] ALL_BITS   = '1;

  logic                  clk_125mhz;
  logic                  rstn_125mhz;
  logic [DATA_W-1:0]     sys_addr_i;
  logic [DATA_W-1:0]     sys_wdata_i;
  logic                  sys_wen_i;
  logic                  sys_ren_i;
  logic [DATA_W-1:0]     sys_rdata_o;
  logic                  sys_ack_o;
  logic                  sys_err_o;
  logic                  x11_activated_o;
  logic                  sha_rdy_i;          // engine model outputs
  logic                  sha_fifo_rd_en_i;
  logic                  sha_hash_valid_i;
  logic [HASH_W-1:0]     sha_hash_i;
  logic                  sha_start_o;
  logic                  sha_fifo_rd_vld_o;
  logic [DATA_W-1:0]     sha_fifo_rd_data_o;

  logic [DATA_W-1:0]     exp_q [$];          // one entry per bus access
  logic [DATA_W-1:0]     mask_q [$];
  string                 name_q [$];
  logic [DATA_W-1:0]     pop_q [$];          // words the engine should see, push order
  logic [DATA_W-1:0]     msg [NUM_WORDS];
  logic [HASH_W-1:0]     hash_ref;
  logic                  ack_due = 1'b0;
  integer                seed = 99;
  int                    cycles = 0;

  tb_clk_gen i_clk_gen (
    .clk_125mhz_o  (clk_125mhz),
    .rstn_125mhz_o (rstn_125mhz)
  );

  x11_regs_top i_dut (.*);

  // each word k is the xor of all message words rotated left by k
  function automatic logic [HASH_W-1:0] expected_hash(input logic [DATA_W-1:0] w [NUM_WORDS]);
    logic [HASH_W-1:0] h;
    logic [63:0]       dbl;
    h = '0;
    for (int k = 0; k < HASH_WORDS; k++) begin
      for (int n = 0; n < NUM_WORDS; n++) begin
        dbl = {w[n], w[n]} >> (32 - k);  // low half is the rotation
        h[k*DATA_W +: DATA_W] = h[k*DATA_W +: DATA_W] ^ dbl[31:0];
      end
    end
    return h;
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // --------------------
  // bus and engine drivers
  // --------------------
  task automatic bus_access(input logic wr, input logic [ADDR_DEC_W-1:0] addr,
                            input logic [31:0] data, input logic [31:0] exp,
                            input logic [31:0] mask, input string name);
    @(posedge clk_125mhz);
    sys_addr_i  <= 32'(addr);
    sys_wdata_i <= data;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    exp_q.push_back(exp);
    mask_q.push_back(mask);   // zero mask for writes
    name_q.push_back(name);
    @(posedge clk_125mhz);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    do @(negedge clk_125mhz); while (!sys_ack_o);  // ack comes back one cycle later
  endtask

  task automatic bus_write(input logic [ADDR_DEC_W-1:0] addr, input logic [31:0] data);
    bus_access(1'b1, addr, data, '0, '0, "write");
  endtask

  task automatic bus_read(input logic [ADDR_DEC_W-1:0] addr, input logic [31:0] exp,
                          input logic [31:0] mask, input string name);
    bus_access(1'b0, addr, '0, exp, mask, name);
  endtask

  task automatic read_hash(input logic [HASH_W-1:0] exp);
    for (int k = 0; k < HASH_WORDS; k++) begin
      bus_read(ADDR_SHA_HASH_H7 + 20'(4 * k), exp[k*DATA_W +: DATA_W], ALL_BITS,
               $sformatf("sys_rdata_o (hash word %0d)", k));  // word 0 is H7
    end
  endtask

  task automatic pop_word();
    @(posedge clk_125mhz);
    sha_fifo_rd_en_i <= 1'b1;
    @(posedge clk_125mhz);
    sha_fifo_rd_en_i <= 1'b0;
    @(negedge clk_125mhz);   // data checked by the compare process
  endtask

  // --------------------
  // compare process
  // --------------------
  always @(negedge clk_125mhz) begin
    if (rstn_125mhz) begin
      check_value("sys_ack_o", 32'(sys_ack_o), 32'(ack_due));
      check_value("sys_err_o", 32'(sys_err_o), '0);
      if (sys_ack_o) begin
        check_value(name_q.pop_front(), sys_rdata_o & mask_q[0], exp_q[0] & mask_q[0]);
        void'(mask_q.pop_front());
        void'(exp_q.pop_front());
      end
      if (sha_fifo_rd_vld_o) begin
        if (pop_q.size() == 0) begin
          $display("FIFO delivered a word although every pushed word was already read");
          abort_run();
        end else begin
          check_value("sha_fifo_rd_data_o", sha_fifo_rd_data_o, pop_q.pop_front());
        end
      end
      ack_due = sys_wen_i | sys_ren_i;  // ack expected one cycle later
    end
  end

  always @(posedge clk_125mhz) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the test sequence did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  // --------------------
  // stimulus
  // --------------------
  initial begin
    sys_addr_i       = '0;
    sys_wdata_i      = '0;
    sys_wen_i        = 1'b0;
    sys_ren_i        = 1'b0;
    sha_rdy_i        = 1'b0;
    sha_fifo_rd_en_i = 1'b0;
    sha_hash_valid_i = 1'b0;
    sha_hash_i       = '0;
    @(posedge rstn_125mhz);
    @(negedge clk_125mhz);
    check_value("x11_activated_o", 32'(x11_activated_o), '0);
    check_value("sha_start_o", 32'(sha_start_o), '0);
    check_value("sha_fifo_rd_vld_o", 32'(sha_fifo_rd_vld_o), '0);

    // reset values
    bus_read(ADDR_CTRL, '0, ALL_BITS, "sys_rdata_o (ctrl)");
    bus_read(ADDR_STATUS, '0, ALL_BITS, "sys_rdata_o (status)");
    bus_read(ADDR_SHA_STATUS, '0, ~(32'h1 << SST_EMPTY), "sys_rdata_o (sha status)");
    bus_read(ADDR_VERSION, CURRENT_DATE, ALL_BITS, "sys_rdata_o (version)");
    bus_read(20'h00300, '0, ALL_BITS, "sys_rdata_o (unmapped)");
    read_hash('0);

    // activation, reset bit, disable
    bus_write(ADDR_CTRL, 32'h1 << CTRL_ENABLE);
    bus_write(ADDR_SHA_CTRL, 32'h1 << SHA_CTRL_ENABLE);
    bus_write(ADDR_KEK_CTRL, 32'h1 << KEK_CTRL_ENABLE);
    bus_read(ADDR_STATUS, 32'h111, ALL_BITS, "sys_rdata_o (status)");  // bits 0, 4, 8
    check_value("x11_activated_o", 32'(x11_activated_o), 32'h1);
    bus_write(ADDR_SHA_CTRL, (32'h1 << SHA_CTRL_ENABLE) | (32'h1 << SHA_CTRL_RESET));
    bus_read(ADDR_SHA_CTRL, 32'h1 << SHA_CTRL_ENABLE, ALL_BITS, "sys_rdata_o (sha ctrl)");
    bus_write(ADDR_CTRL, '0);
    bus_read(ADDR_STATUS, '0, ALL_BITS, "sys_rdata_o (status)");
    check_value("x11_activated_o", 32'(x11_activated_o), '0);
    bus_write(ADDR_CTRL, 32'h1 << CTRL_ENABLE);
    repeat (3) @(posedge clk_125mhz);  // arm, activate, channel release
    bus_read(ADDR_STATUS, 32'h111, ALL_BITS, "sys_rdata_o (status)");

    // fifo accounting
    for (int n = 0; n < NUM_WORDS; n++) begin
      msg[n] = $random(seed);
      pop_q.push_back(msg[n]);
      bus_write(ADDR_SHA_PUSH, msg[n]);
    end
    bus_read(ADDR_SHA_COUNT, NUM_WORDS, ALL_BITS, "sys_rdata_o (count)");
    bus_read(ADDR_SHA_PUSH, NUM_WORDS, ALL_BITS, "sys_rdata_o (push count)");
    bus_read(ADDR_SHA_STATUS, '0, 32'h1 << SST_EMPTY, "sys_rdata_o (sha status empty)");

    // engine model takes the words
    @(posedge clk_125mhz);
    sha_rdy_i <= 1'b1;
    do @(negedge clk_125mhz); while (!sha_start_o);
    for (int n = 0; n < NUM_WORDS; n++) begin
      pop_word();
    end
    pop_word();  // one extra pop on the empty fifo
    check_value("words left unread", 32'(pop_q.size()), '0);
    bus_read(ADDR_SHA_COUNT, '0, ALL_BITS, "sys_rdata_o (count)");

    // engine returns its hash
    hash_ref = expected_hash(msg);
    @(posedge clk_125mhz);
    sha_hash_i       <= hash_ref;
    sha_hash_valid_i <= 1'b1;
    read_hash(hash_ref);
    bus_read(ADDR_SHA_STATUS, 32'h1 << SST_HASH_VLD, 32'h1 << SST_HASH_VLD,
             "sys_rdata_o (sha status hash valid)");
    @(posedge clk_125mhz);
    sha_hash_valid_i <= 1'b0;  // engine drops valid before the channel reset
    bus_write(ADDR_SHA_CTRL, (32'h1 << SHA_CTRL_ENABLE) | (32'h1 << SHA_CTRL_RESET));
    repeat (3) @(posedge clk_125mhz);
    read_hash('0);

    @(negedge clk_125mhz);
    if (exp_q.size() != 0) begin
      $display("%0d bus accesses never got their response", exp_q.size());
      abort_run();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

/* verif/x11_regs_props.sv */
`timescale 1ns/1ps

module x11_regs_props (
  input logic clk_125mhz,
  input logic rstn_125mhz,
  input logic wen_i,         // bus port side
  input logic ren_i,
  input logic ack_i,
  input logic fifo_empty_i,  // fifo side
  input logic pop_en_i,
  input logic pop_vld_i,
  input logic start_i
);

  // ack is only the registered copy of an access
  ack_after_access: assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    ack_i |-> $past(wen_i | ren_i))
    else $error("sys_ack_o high without an access in the cycle before");

  // a pop on an empty fifo must stay silent
  no_vld_from_empty: assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    pop_vld_i |-> $past(pop_en_i && !fifo_empty_i))
    else $error("pop valid although the fifo was empty or not popped");

  start_one_cycle: assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    start_i |=> !start_i)
    else $error("engine start pulse longer than one cycle");

endmodule

// bus port and fifo signals meet at the top level
bind x11_regs_top x11_regs_props i_props (
  .clk_125mhz   (clk_125mhz),
  .rstn_125mhz  (rstn_125mhz),
  .wen_i        (sys_wen_i),
  .ren_i        (sys_ren_i),
  .ack_i        (sys_ack_o),
  .fifo_empty_i (fifo_empty),
  .pop_en_i     (sha_fifo_rd_en_i),
  .pop_vld_i    (sha_fifo_rd_vld_o),
  .start_i      (sha_start_o)
);
